/* files.f */
+incdir+include
source/axi_apb_pkg.sv
source/axi2apb_bridge.sv
source/apb_decoder.sv
source/apb_ram_slave.sv
source/apb_subsystem_top.sv
test/axi_apb_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module axi_apb_tb -f files.f
output=$(./obj_dir/Vaxi_apb_tb || true)
echo "$output"
echo "$output" | grep -qx "TEST OK"

/* test/axi_apb_tb.sv */
`default_nettype none

`include "axi_apb_config.svh"

module axi_apb_tb;
    import axi_apb_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int MAX_CYCLES = 200 * 16 * 20 + 10; // transactions x beats x cycles plus reset

    logic        aclk = 1'b0;
    logic        aresetn;
    axi_ax_t     aw;
    logic        aw_valid;
    logic        aw_ready;
    axi_ax_t     ar;
    logic        ar_valid;
    logic        ar_ready;
    axi_w_t      w;
    logic        w_valid;
    logic        w_ready;
    axi_b_t      b;
    logic        b_valid;
    logic        b_ready;
    axi_r_t      r;
    logic        r_valid;
    logic        r_ready;

    logic [31:0] model [2][`RAM_WORDS];
    logic [31:0] wdata [16];
    logic [3:0]  wstrb [16];
    axi_b_t      b_got;
    axi_r_t      r_got;
    bit          stall; // random ready low phases and valid delays

    apb_subsystem_top dut_i (.*);

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // beat i under the FIXED, INCR and WRAP rules
    function automatic logic [31:0] beat_addr(input axi_ax_t ax, input int i);
        logic [31:0] step;
        logic [31:0] span;
        logic [31:0] low;
        step = 32'd1 << ax.size;
        span = (32'(ax.len) + 32'd1) * step;
        low  = ax.addr - ax.addr % span; // start of the wrap window
        case (ax.burst)
            FIXED:   return ax.addr;
            WRAP:    return low + (ax.addr - low + 32'(i) * step) % span;
            default: return ax.addr + 32'(i) * step;
        endcase
    endfunction

    // false for unmapped or out-of-depth addresses
    function automatic bit map_addr(input logic [31:0] a, output int p, output int idx);
        bit hit0;
        bit hit1;
        hit0 = (a >> `PERIPH_WIN_W) == (`PERIPH0_BASE >> `PERIPH_WIN_W);
        hit1 = (a >> `PERIPH_WIN_W) == (`PERIPH1_BASE >> `PERIPH_WIN_W);
        p    = hit1 ? 1 : 0;
        idx  = int'(a[`PERIPH_WIN_W-1:2]);
        return (hit0 | hit1) && (idx < `RAM_WORDS);
    endfunction

    function automatic axi_ax_t rand_ax(input axi_burst_e kind);
        axi_ax_t ax;
        ax.burst = kind;
        ax.id    = `AXI_ID_W'($urandom);
        ax.size  = 3'($urandom_range(0, 2));
        ax.len   = 8'($urandom_range(0, 15));
        if (kind == WRAP) begin
            ax.len = 8'((2 << $urandom_range(0, 3)) - 1); // 1, 3, 7 or 15
        end
        ax.addr  = ($urandom_range(0, 1) != 0) ? `PERIPH1_BASE : `PERIPH0_BASE;
        ax.addr  = ax.addr + (($urandom_range(0, `RAM_WORDS * 4 - 64) >> ax.size) << ax.size);
        return ax;
    endfunction

    // ch 0 aw, 1 ar, 2 w, 3 b, 4 r; returns just after the falling edge past the transfer
    task automatic transfer(input int ch);
        bit hit;
        hit = 1'b0;
        repeat (stall && ch < 3 ? $urandom_range(0, 3) : 0) @(negedge aclk);
        aw_valid = (ch == 0);
        ar_valid = (ch == 1);
        w_valid  = (ch == 2);
        while (!hit) begin
            b_ready = (ch == 3) && (!stall || $urandom_range(0, 1) != 0);
            r_ready = (ch == 4) && (!stall || $urandom_range(0, 1) != 0);
            #(CLK_PERIOD / 4);
            hit = (aw_valid & aw_ready) | (ar_valid & ar_ready) | (w_valid & w_ready) |
                  (b_valid & b_ready) | (r_valid & r_ready);
            b_got = b;
            r_got = r;
            @(negedge aclk);
        end
        aw_valid = 1'b0;
        ar_valid = 1'b0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        r_ready  = 1'b0;
    endtask

    task automatic run_burst(input axi_ax_t ax, input bit is_read);
        int p;
        int idx;
        bit ok;
        bit err;
        err = 1'b0;
        if (is_read) begin
            ar = ax;
        end else begin
            aw = ax;
        end
        transfer(is_read ? 1 : 0);
        for (int i = 0; i <= int'(ax.len); i++) begin
            ok  = map_addr(beat_addr(ax, i), p, idx);
            err = err | !ok;
            if (is_read) begin
                transfer(4);
                check_val(32'(r_got.id), 32'(ax.id), "rid");
                check_val(32'(r_got.last), 32'(i == int'(ax.len)), "rlast");
                check_val(32'(r_got.resp), 32'(ok ? OKAY : SLVERR), "rresp");
                if (ok) begin
                    check_val(r_got.data, model[p][idx], "rdata");
                end
            end else begin
                w.data = wdata[i];
                w.strb = wstrb[i];
                w.last = (i == int'(ax.len));
                transfer(2);
                for (int k = 0; k < 4; k++) begin
                    if (ok && wstrb[i][k]) begin
                        model[p][idx][8*k +: 8] = wdata[i][8*k +: 8];
                    end
                end
            end
        end
        if (!is_read) begin
            transfer(3);
            check_val(32'(b_got.id), 32'(ax.id), "bid");
            check_val(32'(b_got.resp), 32'(err ? SLVERR : OKAY), "bresp");
        end
        check_val(32'(r_valid | b_valid), 32'd0, "valid after the last response");
    endtask

    task automatic write_read(input axi_ax_t ax);
        for (int i = 0; i < 16; i++) begin
            wdata[i] = $urandom;
            wstrb[i] = 4'($urandom);
        end
        run_burst(ax, 1'b0);
        run_burst(ax, 1'b1);
    endtask

    initial begin
        axi_ax_t     ax;
        logic [31:0] a;
        aresetn  = 1'b0;
        aw       = '0;
        aw_valid = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        r_ready  = 1'b0;
        stall    = 1'b0;
        void'($urandom(32'hcc43_b3c1));
        repeat (10) @(negedge aclk);
        aresetn = 1'b1;

        // preload every word of both RAMs
        for (int n = 0; n < `RAM_WORDS / 8; n++) begin
            ax.addr  = (n < `RAM_WORDS / 16) ? `PERIPH0_BASE : `PERIPH1_BASE;
            ax.addr  = ax.addr + 32'((n % (`RAM_WORDS / 16)) * 64);
            ax.id    = `AXI_ID_W'(n);
            ax.len   = 8'd15;
            ax.size  = 3'd2;
            ax.burst = INCR;
            for (int i = 0; i < 16; i++) begin
                a        = beat_addr(ax, i);
                wdata[i] = (a * 32'h0101_0101) ^ {a[7:0], a[31:8]};
                wstrb[i] = 4'hf;
            end
            run_burst(ax, 1'b0);
        end

        repeat (8) begin
            ax     = rand_ax(INCR);
            ax.len = 8'd0; // single beat
            write_read(ax);
        end
        repeat (30) begin
            write_read(rand_ax(($urandom_range(0, 1) != 0) ? INCR : FIXED));
        end
        repeat (12) begin
            write_read(rand_ax(WRAP));
        end
        for (int n = 0; n < 10; n++) begin
            ax           = rand_ax(INCR);
            ax.size      = 3'd2;
            ax.len       = 8'($urandom_range(8, 15));
            ax.addr[9:0] = 10'h3e0; // from word 248 past the RAM depth
            if (n % 2 == 1) begin
                ax.addr = ax.addr + 32'h0000_2000; // outside both windows
            end
            write_read(ax);
        end
        // words that share index bits with the out-of-depth beats
        for (int n = 0; n < 2; n++) begin
            ax.addr  = (n == 0) ? `PERIPH0_BASE : `PERIPH1_BASE;
            ax.id    = `AXI_ID_W'(n);
            ax.len   = 8'd7;
            ax.size  = 3'd2;
            ax.burst = INCR;
            run_burst(ax, 1'b1);
        end
        stall = 1'b1;
        repeat (20) begin
            write_read(rand_ax(axi_burst_e'(2'($urandom_range(0, 2)))));
        end

        $display("TEST OK");
        $finish;
    end

    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("timed out after %0d clock cycles before the test sequence ended", MAX_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* source/apb_subsystem_top.sv */
`default_nettype none

`include "axi_apb_config.svh"

module apb_subsystem_top (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  axi_apb_pkg::axi_ax_t aw,
    input  logic                 aw_valid,
    output logic                 aw_ready,
    input  axi_apb_pkg::axi_ax_t ar,
    input  logic                 ar_valid,
    output logic                 ar_ready,
    input  axi_apb_pkg::axi_w_t  w,
    input  logic                 w_valid,
    output logic                 w_ready,
    output axi_apb_pkg::axi_b_t  b,
    output logic                 b_valid,
    input  logic                 b_ready,
    output axi_apb_pkg::axi_r_t  r,
    output logic                 r_valid,
    input  logic                 r_ready
);
    import axi_apb_pkg::*;

    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    apb_req_t periph_req [2];
    apb_rsp_t periph_rsp [2];

    axi2apb_bridge bridge_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp)
    );

    apb_decoder decoder_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .periph_req (periph_req),
        .periph_rsp (periph_rsp)
    );

    apb_ram_slave #(
        .WAIT_STATES (0),
        .DEPTH       (`RAM_WORDS)
    ) periph0 (
        .aclk    (aclk),
        .aresetn (aresetn),
        .req     (periph_req[0]),
        .rsp     (periph_rsp[0])
    );

    // slower peripheral
    apb_ram_slave #(
        .WAIT_STATES (2),
        .DEPTH       (`RAM_WORDS)
    ) periph1 (
        .aclk    (aclk),
        .aresetn (aresetn),
        .req     (periph_req[1]),
        .rsp     (periph_rsp[1])
    );

endmodule

`default_nettype wire

/* source/apb_ram_slave.sv */
`default_nettype none

`include "axi_apb_config.svh"

module apb_ram_slave #(
    parameter int WAIT_STATES = 0,
    parameter int DEPTH       = 256
) (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  axi_apb_pkg::apb_req_t req,
    output axi_apb_pkg::apb_rsp_t rsp
);
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
    localparam int IDX_W = `PERIPH_WIN_W - 2;
    localparam int MEM_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [`AXI_DATA_W-1:0] mem [DEPTH];

    logic [CNT_W-1:0]       wait_cnt;
    logic                   access;
    logic                   done;
    logic                   in_range;
    logic [IDX_W-1:0]       word_idx;
    logic [MEM_W-1:0]       mem_idx;

    assign access   = req.psel & req.penable;
    assign done     = access & (wait_cnt == CNT_W'(WAIT_STATES));
    assign word_idx = req.paddr[`PERIPH_WIN_W-1:2]; // word offset in the window
    assign in_range = (int'(word_idx) < DEPTH);
    assign mem_idx  = word_idx[MEM_W-1:0];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wait_cnt <= '0;
        end else if (access && !done) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // write lands on the pready cycle
    always_ff @(posedge aclk) begin
        if (done && req.pwrite && in_range) begin
            for (int i = 0; i < `AXI_STRB_W; i++) begin
                if (req.pstrb[i]) begin
                    mem[mem_idx][8*i +: 8] <= req.pwdata[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        rsp.pready  = done;
        rsp.pslverr = done & ~in_range;
        rsp.prdata  = in_range ? mem[mem_idx] : '0;
    end

endmodule

`default_nettype wire

/* source/apb_decoder.sv */
`default_nettype none

`include "axi_apb_config.svh"

module apb_decoder (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  axi_apb_pkg::apb_req_t apb_req,
    output axi_apb_pkg::apb_rsp_t apb_rsp,
    output axi_apb_pkg::apb_req_t periph_req [2],
    input  axi_apb_pkg::apb_rsp_t periph_rsp [2]
);
    localparam logic [`AXI_ADDR_W-1:0] BASE [2] = '{`PERIPH0_BASE, `PERIPH1_BASE};

    logic [1:0] hit;
    logic [1:0] hit_q; // one-hot, zero when unmapped

    for (genvar i = 0; i < 2; i++) begin : g_periph
        assign hit[i] = (apb_req.paddr[`AXI_ADDR_W-1:`PERIPH_WIN_W] ==
                         BASE[i][`AXI_ADDR_W-1:`PERIPH_WIN_W]);

        always_comb begin
            periph_req[i]      = apb_req;
            periph_req[i].psel = apb_req.psel & hit[i];
        end
    end

    // captured in the setup phase, paddr is stable through the access
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            hit_q <= 2'b00;
        end else if (apb_req.psel && !apb_req.penable) begin
            hit_q <= hit;
        end
    end

    always_comb begin
        // default error slave answers in the first access cycle
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = apb_req.psel & apb_req.penable;
        apb_rsp.pslverr = apb_req.psel & apb_req.penable;
        if (hit_q[0]) begin
            apb_rsp = periph_rsp[0];
        end else if (hit_q[1]) begin
            apb_rsp = periph_rsp[1];
        end
    end

endmodule

`default_nettype wire

/* source/axi2apb_bridge.sv */
`default_nettype none

`include "axi_apb_config.svh"

module axi2apb_bridge (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  axi_apb_pkg::axi_ax_t  aw,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  axi_apb_pkg::axi_ax_t  ar,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  axi_apb_pkg::axi_w_t   w,
    input  logic                  w_valid,
    output logic                  w_ready,
    output axi_apb_pkg::axi_b_t   b,
    output logic                  b_valid,
    input  logic                  b_ready,
    output axi_apb_pkg::axi_r_t   r,
    output logic                  r_valid,
    input  logic                  r_ready,
    output axi_apb_pkg::apb_req_t apb_req,
    input  axi_apb_pkg::apb_rsp_t apb_rsp
);
    import axi_apb_pkg::*;

    bridge_state_e          state;
    bridge_state_e          state_nxt;

    logic [`AXI_ID_W-1:0]   id_q;
    logic [7:0]             cnt_q;
    logic [2:0]             size_q;
    logic [`AXI_ADDR_W-1:0] addr_q;
    logic [`AXI_ADDR_W-1:0] mask_q;
    logic [`AXI_DATA_W-1:0] rdata_q;
    logic                   err_q;
    logic                   penable_q;

    axi_ax_t                req_sel;
    logic                   accept;
    logic                   psel;
    logic                   apb_done;
    logic                   beat_done;
    logic                   last_beat;

    // set bits of the mask hold the address, clear bits advance
    function automatic logic [`AXI_ADDR_W-1:0] wrap_mask(input axi_ax_t ax);
        logic [`AXI_ADDR_W-1:0] span;
        span = (`AXI_ADDR_W'(ax.len) + 1'b1) << ax.size;
        case (ax.burst)
            FIXED:   return '1;
            WRAP:    return ~(span - 1'b1);
            default: return '0;
        endcase
    endfunction

    assign req_sel   = ar_valid ? ar : aw; // read wins
    assign accept    = (state == IDLE) & (ar_valid | aw_valid);
    assign last_beat = (cnt_q == 8'd0);
    assign apb_done  = psel & penable_q & apb_rsp.pready;
    assign beat_done = ((state == WR) & apb_done) | ((state == RRESP) & r_ready);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (ar_valid) begin
                    state_nxt = RD;
                end else if (aw_valid) begin
                    state_nxt = WR;
                end
            end
            WR: begin
                if (apb_done && last_beat) begin
                    state_nxt = BRESP;
                end
            end
            BRESP: begin
                if (b_ready) begin
                    state_nxt = IDLE;
                end
            end
            RD: begin
                if (apb_done) begin
                    state_nxt = RRESP;
                end
            end
            RRESP: begin
                if (r_ready) begin
                    state_nxt = last_beat ? IDLE : RD;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    assign ar_ready = (state == IDLE) & ar_valid;
    assign aw_ready = (state == IDLE) & aw_valid & ~ar_valid;
    assign w_ready  = (state == WR) & apb_done;
    assign b_valid  = (state == BRESP);
    assign r_valid  = (state == RRESP);
    assign psel     = ((state == WR) & w_valid) | (state == RD);

    always_comb begin
        apb_req.paddr   = addr_q;
        apb_req.psel    = psel;
        apb_req.penable = penable_q;
        apb_req.pwrite  = (state == WR);
        apb_req.pwdata  = w.data;
        apb_req.pstrb   = (state == WR) ? w.strb : '0; // no strobes on reads

        b.id   = id_q;
        b.resp = err_q ? SLVERR : OKAY;

        r.id   = id_q;
        r.data = rdata_q;
        r.resp = err_q ? SLVERR : OKAY;
        r.last = last_beat;
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= IDLE;
            cnt_q     <= 8'd0;
            err_q     <= 1'b0;
            penable_q <= 1'b0;
        end else begin
            state     <= state_nxt;
            penable_q <= psel & ~apb_done; // access phase after setup

            if (accept) begin
                cnt_q <= req_sel.len;
            end else if (beat_done && !last_beat) begin
                cnt_q <= cnt_q - 8'd1;
            end

            if (accept) begin
                err_q <= 1'b0;
            end else if ((state == RD) && apb_done) begin
                err_q <= apb_rsp.pslverr; // per beat
            end else if ((state == WR) && apb_done) begin
                err_q <= err_q | apb_rsp.pslverr; // sticky over the burst
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            id_q   <= req_sel.id;
            size_q <= req_sel.size;
            addr_q <= req_sel.addr;
            mask_q <= wrap_mask(req_sel);
        end else if (beat_done) begin
            addr_q <= (addr_q & mask_q) |
                      ((addr_q + (`AXI_ADDR_W'(1) << size_q)) & ~mask_q);
        end

        if ((state == RD) && apb_done) begin
            rdata_q <= apb_rsp.prdata;
        end
    end

endmodule

`default_nettype wire

/* source/axi_apb_pkg.sv */
`default_nettype none

`include "axi_apb_config.svh"

package axi_apb_pkg;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic [2:0] {
        IDLE,
        WR,
        BRESP,
        RD,
        RRESP
    } bridge_state_e;

    // shared by AW and AR
    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_ID_W-1:0]   id;
        logic [7:0]             len;
        logic [2:0]             size;
        axi_burst_e             burst;
    } axi_ax_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_STRB_W-1:0] strb;
        logic                   last;
    } axi_w_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0] id;
        axi_resp_e            resp;
    } axi_b_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
        axi_resp_e              resp;
        logic                   last;
    } axi_r_t;

    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] paddr;
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`AXI_DATA_W-1:0] pwdata;
        logic [`AXI_STRB_W-1:0] pstrb;
    } apb_req_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* include/axi_apb_config.svh */
`ifndef AXI_APB_CONFIG_SVH
`define AXI_APB_CONFIG_SVH

// AXI slave port widths
`define AXI_ADDR_W      32
`define AXI_DATA_W      32
`define AXI_ID_W        4
`define AXI_STRB_W      (`AXI_DATA_W / 8)

// depth of each RAM peripheral, in words
`define RAM_WORDS       256

// peripheral windows, 4 KiB each
`define PERIPH_WIN_W    12
`define PERIPH0_BASE    32'h0000_0000
`define PERIPH1_BASE    32'h0000_1000

`endif
